// ==== hdl/camera_consts.svh ====
////////////////////////////////////////////////////////////
// Camera capture sizes
// Coordinate width, byte buffer depth and byte count width
// shared by the crop, buffer and command blocks
////////////////////////////////////////////////////////////

`ifndef CAMERA_CONSTS_SVH
`define CAMERA_CONSTS_SVH

// Width of column and row positions and crop bounds (frames up to 256 x 256)
`define CAM_COORD_BITS 8

// Image buffer size in bytes
`define CAM_BUFFER_DEPTH 4096

// Byte count wide enough to hold CAM_BUFFER_DEPTH itself
`define CAM_COUNT_BITS 13

`endif

// ==== hdl/camera_pkg.sv ====
////////////////////////////////////////////////////////////
// Camera capture types
// Command opcodes, crop states and pixel and count types
////////////////////////////////////////////////////////////

`include "camera_consts.svh"

package camera_pkg;

    typedef enum logic [7:0] {
        CMD_CAPTURE       = 8'h10,
        CMD_SET_X_START   = 8'h20,
        CMD_SET_X_END     = 8'h21,
        CMD_SET_Y_START   = 8'h22,
        CMD_SET_Y_END     = 8'h23,
        CMD_READ_STATUS   = 8'h30,
        CMD_READ_PEAK     = 8'h31,
        CMD_READ_CLIPPED  = 8'h32,
        CMD_READ_COUNT_HI = 8'h33,
        CMD_READ_COUNT_LO = 8'h34,
        CMD_READ_DATA     = 8'h40
    } cmd_opcode_e;

    typedef enum logic [1:0] {
        CROP_IDLE,
        CROP_ARMED,
        CROP_CAPTURING
    } crop_state_e;

    typedef logic [7:0] pixel_byte_t;                   // Stored image byte
    typedef logic [9:0] raw_pixel_t;                    // Raw Bayer sample
    typedef logic [`CAM_COUNT_BITS-1:0] byte_count_t;

endpackage

// ==== hdl/pixel_crop.sv ====
////////////////////////////////////////////////////////////
// Pixel crop
// Arms on a capture strobe, takes the next whole frame and
// passes the top byte of every pixel inside the window
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_consts.svh"

module pixel_crop import camera_pkg::*; (
    input  logic                       mipi_byte_clock,
    input  logic                       mipi_byte_reset_n,

    input  logic                       capture_i,
    input  logic [`CAM_COORD_BITS-1:0] x_start_i,
    input  logic [`CAM_COORD_BITS-1:0] x_end_i,
    input  logic [`CAM_COORD_BITS-1:0] y_start_i,
    input  logic [`CAM_COORD_BITS-1:0] y_end_i,

    input  logic                       frame_valid_i,
    input  logic                       line_valid_i,
    input  raw_pixel_t                 pixel_data_i,

    output logic                       crop_valid_o,
    output pixel_byte_t                crop_data_o,
    output logic                       frame_start_o,
    output logic                       frame_end_o,
    output logic                       busy_o
);

crop_state_e state;
logic frame_valid_q;
logic line_valid_q;
logic [`CAM_COORD_BITS-1:0] x_pos;
logic [`CAM_COORD_BITS-1:0] y_pos;
logic frame_rise;
logic frame_fall;
logic line_fall;
logic in_window;
logic taking;

assign frame_rise = frame_valid_i & ~frame_valid_q;
assign frame_fall = ~frame_valid_i & frame_valid_q;
assign line_fall  = ~line_valid_i & line_valid_q;

assign in_window = (x_pos >= x_start_i) && (x_pos < x_end_i) &&
                   (y_pos >= y_start_i) && (y_pos < y_end_i);

// First line may open in the same cycle as the frame
assign taking = (state == CROP_CAPTURING) || ((state == CROP_ARMED) && frame_rise);

assign busy_o = (state != CROP_IDLE);

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        state         <= CROP_IDLE;
        frame_valid_q <= 1'b0;
        line_valid_q  <= 1'b0;
        x_pos         <= '0;
        y_pos         <= '0;
        crop_valid_o  <= 1'b0;
        frame_start_o <= 1'b0;
        frame_end_o   <= 1'b0;
    end else begin
        frame_valid_q <= frame_valid_i;
        line_valid_q  <= line_valid_i;

        x_pos <= line_valid_i ? x_pos + 1'b1 : '0;      // Column within the line
        if (!frame_valid_i) begin
            y_pos <= '0;
        end else if (line_fall) begin
            y_pos <= y_pos + 1'b1;                      // Next row after each line
        end

        crop_valid_o  <= taking && frame_valid_i && line_valid_i && in_window;
        frame_start_o <= (state == CROP_ARMED) && frame_rise;
        frame_end_o   <= (state == CROP_CAPTURING) && frame_fall;

        // A capture during an active capture is ignored
        case (state)
            CROP_IDLE:      if (capture_i) state <= CROP_ARMED;
            CROP_ARMED:     if (frame_rise) state <= CROP_CAPTURING;
            CROP_CAPTURING: if (frame_fall) state <= CROP_IDLE;
            default:        state <= CROP_IDLE;
        endcase
    end
end

always_ff @(posedge mipi_byte_clock) begin
    crop_data_o <= pixel_data_i[9:2];                   // Keep the top 8 bits
end

endmodule

// ==== hdl/frame_metering.sv ====
////////////////////////////////////////////////////////////
// Frame metering
// Peak byte and clipped pixel count over the cropped frame,
// published when the frame ends
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frame_metering import camera_pkg::*; (
    input  logic        mipi_byte_clock,
    input  logic        mipi_byte_reset_n,

    input  logic        crop_valid_i,
    input  pixel_byte_t crop_data_i,
    input  logic        frame_start_i,
    input  logic        frame_end_i,

    output pixel_byte_t peak_o,
    output logic [7:0]  clipped_o
);

pixel_byte_t peak_run;
logic [7:0] clipped_run;
logic is_clipped;

assign is_clipped = crop_valid_i && (crop_data_i == 8'hFF);

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        peak_run    <= '0;
        clipped_run <= '0;
        peak_o      <= '0;
        clipped_o   <= '0;
    end else begin
        if (frame_start_i) begin
            // First kept pixel can share the frame start cycle
            peak_run    <= crop_valid_i ? crop_data_i : '0;
            clipped_run <= is_clipped ? 8'd1 : 8'd0;
        end else if (crop_valid_i) begin
            if (crop_data_i > peak_run) peak_run <= crop_data_i;
            if (is_clipped && (clipped_run != 8'hFF)) begin
                clipped_run <= clipped_run + 8'd1;      // Saturates at 255
            end
        end

        if (frame_end_i) begin
            peak_o    <= peak_run;
            clipped_o <= clipped_run;
        end
    end
end

endmodule

// ==== hdl/image_buffer.sv ====
////////////////////////////////////////////////////////////
// Image buffer
// Byte RAM filled in raster order from the crop stream,
// with a saturating write pointer and a complete flag
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_consts.svh"

module image_buffer import camera_pkg::*; (
    input  logic        mipi_byte_clock,
    input  logic        mipi_byte_reset_n,

    input  logic        crop_valid_i,
    input  pixel_byte_t crop_data_i,
    input  logic        frame_start_i,
    input  logic        frame_end_i,

    input  logic        read_enable_i,
    input  byte_count_t read_address_i,
    output pixel_byte_t read_data_o,

    output byte_count_t byte_count_o,
    output logic        image_complete_o
);

localparam int ADDR_BITS = $clog2(`CAM_BUFFER_DEPTH);

pixel_byte_t mem [`CAM_BUFFER_DEPTH];
byte_count_t write_ptr;
byte_count_t write_addr;
logic write_enable;
logic buffer_full;

assign write_addr   = frame_start_i ? '0 : write_ptr;   // Restart with the new frame
assign buffer_full  = (write_addr == byte_count_t'(`CAM_BUFFER_DEPTH));
assign write_enable = crop_valid_i && !buffer_full;
assign byte_count_o = write_ptr;

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        write_ptr        <= '0;
        image_complete_o <= 1'b0;
    end else begin
        if (write_enable) begin
            write_ptr <= write_addr + 1'b1;
        end else if (frame_start_i) begin
            write_ptr <= '0;
        end

        if (frame_start_i) begin
            image_complete_o <= 1'b0;
        end else if (frame_end_i) begin
            image_complete_o <= 1'b1;
        end
    end
end

always_ff @(posedge mipi_byte_clock) begin
    if (write_enable) mem[write_addr[ADDR_BITS-1:0]] <= crop_data_i;
    if (read_enable_i) read_data_o <= mem[read_address_i[ADDR_BITS-1:0]];
end

endmodule

// ==== hdl/command_registers.sv ====
////////////////////////////////////////////////////////////
// Command registers
// Decodes the byte command port, holds the crop window,
// issues captures and returns status, meter and image reads
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_consts.svh"

module command_registers import camera_pkg::*; (
    input  logic                       mipi_byte_clock,
    input  logic                       mipi_byte_reset_n,

    input  logic [7:0]                 op_code_i,
    input  logic                       op_code_valid_i,
    input  logic [7:0]                 operand_i,
    input  logic                       operand_valid_i,
    input  integer                     operand_count_i,
    output logic [7:0]                 response_o,
    output logic                       response_valid_o,

    output logic                       capture_o,
    output logic [`CAM_COORD_BITS-1:0] x_start_o,
    output logic [`CAM_COORD_BITS-1:0] x_end_o,
    output logic [`CAM_COORD_BITS-1:0] y_start_o,
    output logic [`CAM_COORD_BITS-1:0] y_end_o,

    input  logic                       busy_i,
    input  logic                       image_complete_i,
    input  byte_count_t                byte_count_i,
    input  pixel_byte_t                peak_i,
    input  logic [7:0]                 clipped_i,

    output logic                       read_enable_o,
    output byte_count_t                read_address_o,
    input  pixel_byte_t                read_data_i
);

cmd_opcode_e opcode;
cmd_opcode_e pending_op;
logic pending_valid;
logic accept;
logic is_read;
logic is_set;
logic read_pending_q;
logic data_sel_q;
pixel_byte_t reg_value;
pixel_byte_t reg_value_q;
byte_count_t read_ptr;

assign opcode  = cmd_opcode_e'(op_code_i);
assign accept  = op_code_valid_i && !read_pending_q;    // Busy for one cycle after a read
assign is_read = opcode inside {CMD_READ_STATUS, CMD_READ_PEAK, CMD_READ_CLIPPED,
                                CMD_READ_COUNT_HI, CMD_READ_COUNT_LO, CMD_READ_DATA};
assign is_set  = opcode inside {CMD_SET_X_START, CMD_SET_X_END,
                                CMD_SET_Y_START, CMD_SET_Y_END};

// Data past the stored count reads as zero without a RAM access
assign read_enable_o  = accept && (opcode == CMD_READ_DATA) && (read_ptr < byte_count_i);
assign read_address_o = read_ptr;

always_comb begin
    case (opcode)
        CMD_READ_STATUS:   reg_value = {6'b0, busy_i, image_complete_i};
        CMD_READ_PEAK:     reg_value = peak_i;
        CMD_READ_CLIPPED:  reg_value = clipped_i;
        CMD_READ_COUNT_HI: reg_value = pixel_byte_t'(byte_count_i >> 8);
        CMD_READ_COUNT_LO: reg_value = byte_count_i[7:0];
        default:           reg_value = '0;
    endcase
end

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        pending_op       <= CMD_SET_X_START;
        pending_valid    <= 1'b0;
        read_pending_q   <= 1'b0;
        data_sel_q       <= 1'b0;
        response_o       <= '0;
        response_valid_o <= 1'b0;
        capture_o        <= 1'b0;
        read_ptr         <= '0;
        x_start_o        <= '0;
        x_end_o          <= '1;                         // Full frame by default
        y_start_o        <= '0;
        y_end_o          <= '1;
    end else begin
        read_pending_q   <= accept && is_read;
        data_sel_q       <= read_enable_o;
        response_valid_o <= read_pending_q;
        response_o       <= data_sel_q ? read_data_i : reg_value_q;
        capture_o        <= accept && (opcode == CMD_CAPTURE);

        if (accept && (opcode == CMD_CAPTURE)) begin
            read_ptr <= '0;
        end else if (read_enable_o) begin
            read_ptr <= read_ptr + 1'b1;
        end

        // Set commands use operand 0 only
        if (operand_valid_i && pending_valid && (operand_count_i == 0)) begin
            pending_valid <= 1'b0;
            case (pending_op)
                CMD_SET_X_START: x_start_o <= `CAM_COORD_BITS'(operand_i);
                CMD_SET_X_END:   x_end_o   <= `CAM_COORD_BITS'(operand_i);
                CMD_SET_Y_START: y_start_o <= `CAM_COORD_BITS'(operand_i);
                CMD_SET_Y_END:   y_end_o   <= `CAM_COORD_BITS'(operand_i);
                default:         pending_valid <= 1'b0;
            endcase
        end

        if (accept) begin
            pending_valid <= is_set;                    // Any other opcode drops a stale set
            if (is_set) pending_op <= opcode;
        end
    end
end

always_ff @(posedge mipi_byte_clock) begin
    reg_value_q <= reg_value;                           // Lines up with the RAM read
end

endmodule

// ==== hdl/camera.sv ====
////////////////////////////////////////////////////////////
// Camera capture top level
// Command port, window crop, metering and image buffer,
// all on the MIPI byte clock
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_consts.svh"

module camera import camera_pkg::*; (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,

    input  logic       frame_valid_i,
    input  logic       line_valid_i,
    input  raw_pixel_t pixel_data_i,

    input  logic [7:0] op_code_i,
    input  logic       op_code_valid_i,
    input  logic [7:0] operand_i,
    input  logic       operand_valid_i,
    input  integer     operand_count_i,
    output logic [7:0] response_o,
    output logic       response_valid_o
);

logic capture;
logic [`CAM_COORD_BITS-1:0] x_start;
logic [`CAM_COORD_BITS-1:0] x_end;
logic [`CAM_COORD_BITS-1:0] y_start;
logic [`CAM_COORD_BITS-1:0] y_end;
logic crop_valid;
pixel_byte_t crop_data;
logic frame_start;
logic frame_end;
logic busy;
logic image_complete;
byte_count_t byte_count;
logic read_enable;
byte_count_t read_address;
pixel_byte_t read_data;
pixel_byte_t peak;
logic [7:0] clipped;

command_registers u_command_registers (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .op_code_i         (op_code_i),
    .op_code_valid_i   (op_code_valid_i),
    .operand_i         (operand_i),
    .operand_valid_i   (operand_valid_i),
    .operand_count_i   (operand_count_i),
    .response_o        (response_o),
    .response_valid_o  (response_valid_o),
    .capture_o         (capture),
    .x_start_o         (x_start),
    .x_end_o           (x_end),
    .y_start_o         (y_start),
    .y_end_o           (y_end),
    .busy_i            (busy),
    .image_complete_i  (image_complete),
    .byte_count_i      (byte_count),
    .peak_i            (peak),
    .clipped_i         (clipped),
    .read_enable_o     (read_enable),
    .read_address_o    (read_address),
    .read_data_i       (read_data)
);

pixel_crop u_pixel_crop (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .capture_i         (capture),
    .x_start_i         (x_start),
    .x_end_i           (x_end),
    .y_start_i         (y_start),
    .y_end_i           (y_end),
    .frame_valid_i     (frame_valid_i),
    .line_valid_i      (line_valid_i),
    .pixel_data_i      (pixel_data_i),
    .crop_valid_o      (crop_valid),
    .crop_data_o       (crop_data),
    .frame_start_o     (frame_start),
    .frame_end_o       (frame_end),
    .busy_o            (busy)
);

// Second reader of the crop stream
frame_metering u_frame_metering (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .crop_valid_i      (crop_valid),
    .crop_data_i       (crop_data),
    .frame_start_i     (frame_start),
    .frame_end_i       (frame_end),
    .peak_o            (peak),
    .clipped_o         (clipped)
);

image_buffer u_image_buffer (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .crop_valid_i      (crop_valid),
    .crop_data_i       (crop_data),
    .frame_start_i     (frame_start),
    .frame_end_i       (frame_end),
    .read_enable_i     (read_enable),
    .read_address_i    (read_address),
    .read_data_o       (read_data),
    .byte_count_o      (byte_count),
    .image_complete_o  (image_complete)
);

endmodule

// ==== verification/camera_asserts.sv ====
////////////////////////////////////////////////////////////
// Camera capture assertions
// Read response latency, crop stream gating and buffer
// write pointer range, bound into the top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_consts.svh"

module camera_asserts import camera_pkg::*; (
    input  logic        mipi_byte_clock,
    input  logic        mipi_byte_reset_n,
    input  logic [7:0]  op_code_i,
    input  logic        op_code_valid_i,
    input  logic        response_valid_i,
    input  logic        crop_valid_i,
    input  crop_state_e crop_state_i,
    input  byte_count_t write_ptr_i
);

logic read_op;

assign read_op = op_code_valid_i &&
                 (cmd_opcode_e'(op_code_i) inside {CMD_READ_STATUS, CMD_READ_PEAK,
                  CMD_READ_CLIPPED, CMD_READ_COUNT_HI, CMD_READ_COUNT_LO, CMD_READ_DATA});

assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    response_valid_i |-> $past(read_op, 2))
    else $error("response valid without a read opcode two cycles before");

assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    crop_valid_i |-> (crop_state_i == CROP_CAPTURING))
    else $error("crop valid outside a capturing frame");

assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    write_ptr_i <= byte_count_t'(`CAM_BUFFER_DEPTH))
    else $error("buffer write pointer beyond the depth");

endmodule

bind camera camera_asserts u_camera_asserts (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .op_code_i         (op_code_i),
    .op_code_valid_i   (op_code_valid_i),
    .response_valid_i  (response_valid_o),
    .crop_valid_i      (crop_valid),
    .crop_state_i      (u_pixel_crop.state),
    .write_ptr_i       (u_image_buffer.write_ptr)
);

// ==== verification/camera_tb.sv ====
////////////////////////////////////////////////////////////
// Camera capture testbench
// Drives frames and byte commands into the capture top level
// and checks crop, metering and buffer reads against a model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_consts.svh"

module camera_tb import camera_pkg::*; ();

localparam int LINE_GAP  = 2;                           // Blank cycles after each line
localparam int FRAME_GAP = 4;

function automatic int frame_cycles(input int width, input int height);
    return 2 + height * (width + LINE_GAP) + FRAME_GAP;
endfunction

localparam int FRAME_TOTAL = 6 * frame_cycles(16, 12) + frame_cycles(32, 24) +
                             frame_cycles(80, 60);
localparam int READ_TOTAL  = 3 * (`CAM_BUFFER_DEPTH + 512);
localparam int WATCHDOG_CYCLES = 2 * (FRAME_TOTAL + READ_TOTAL) + 1000;

logic mipi_byte_clock;
logic mipi_byte_reset_n;
logic frame_valid;
logic line_valid;
raw_pixel_t pixel_data;
logic [7:0] op_code;
logic op_code_valid;
logic [7:0] operand;
logic operand_valid;
integer operand_count;
logic [7:0] response;
logic response_valid;

logic [31:0] lfsr_state = 32'hb995_5088;
string test_name = "";
int win_x_start = 0;
int win_x_end = 255;
int win_y_start = 0;
int win_y_end = 255;
pixel_byte_t frame_bytes[$];                            // Kept bytes of the last frame sent
pixel_byte_t stored[$];                                 // Expected buffer contents
pixel_byte_t frame_peak;
int clipped_total;

camera u_dut (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .frame_valid_i     (frame_valid),
    .line_valid_i      (line_valid),
    .pixel_data_i      (pixel_data),
    .op_code_i         (op_code),
    .op_code_valid_i   (op_code_valid),
    .operand_i         (operand),
    .operand_valid_i   (operand_valid),
    .operand_count_i   (operand_count),
    .response_o        (response),
    .response_valid_o  (response_valid)
);

initial begin
    mipi_byte_clock = 1'b0;
    forever #50 mipi_byte_clock = ~mipi_byte_clock;
end

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_byte(input string what, input pixel_byte_t expected,
                          input pixel_byte_t actual);
    if (actual !== expected) begin
        fail_run($sformatf("CHECK FAILED %s, %s: expected 8'h%02h, actual 8'h%02h",
                           test_name, what, expected, actual));
    end
endtask

task automatic check_count(input string what, input byte_count_t expected,
                           input byte_count_t actual);
    if (actual !== expected) begin
        fail_run($sformatf("CHECK FAILED %s, %s: expected %0d, actual %0d",
                           test_name, what, expected, actual));
    end
endtask

// Galois LFSR stepped once per bit
function automatic logic take_bit();
    logic bit_out;
    bit_out = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (bit_out ? 32'h8020_0003 : 32'h0);
    return bit_out;
endfunction

function automatic raw_pixel_t random_pixel(input logic bright);
    raw_pixel_t value;
    value = '0;
    for (int i = 0; i < 10; i++) value = {value[8:0], take_bit()};
    if (bright && take_bit()) value = value | 10'h3FC;  // Top byte forced to 255
    return value;
endfunction

task automatic send_frame(input int width, input int height, input logic bright);
    raw_pixel_t pixel;
    pixel_byte_t kept;
    frame_bytes.delete();
    frame_peak = 8'h00;
    clipped_total = 0;
    @(posedge mipi_byte_clock);
    frame_valid <= 1'b1;
    for (int y = 0; y < height; y++) begin
        for (int x = 0; x < width; x++) begin
            pixel = random_pixel(bright);
            @(posedge mipi_byte_clock);
            line_valid <= 1'b1;
            pixel_data <= pixel;
            if (x >= win_x_start && x < win_x_end && y >= win_y_start && y < win_y_end) begin
                kept = pixel[9:2];
                frame_bytes.push_back(kept);
                if (kept > frame_peak) frame_peak = kept;
                if (kept == 8'hFF) clipped_total++;
            end
        end
        repeat (LINE_GAP) begin
            @(posedge mipi_byte_clock);
            line_valid <= 1'b0;
        end
    end
    @(posedge mipi_byte_clock);
    frame_valid <= 1'b0;
    repeat (FRAME_GAP) @(posedge mipi_byte_clock);  // Frame end reaches the meter and buffer
endtask

// Set and capture opcodes get no response
task automatic send_command(input cmd_opcode_e op, input logic has_operand,
                            input pixel_byte_t value);
    @(posedge mipi_byte_clock);
    op_code       <= op;
    op_code_valid <= 1'b1;
    @(posedge mipi_byte_clock);
    op_code_valid <= 1'b0;
    operand_valid <= has_operand;
    operand       <= value;
    operand_count <= 0;
    @(posedge mipi_byte_clock);
    operand_valid <= 1'b0;
    @(negedge mipi_byte_clock);
    if (response_valid !== 1'b0) begin
        fail_run($sformatf("%s: %s gave a response", test_name, op.name()));
    end
endtask

task automatic read_byte(input cmd_opcode_e op, output pixel_byte_t value);
    @(posedge mipi_byte_clock);
    op_code       <= op;
    op_code_valid <= 1'b1;
    @(posedge mipi_byte_clock);
    op_code_valid <= 1'b0;
    @(posedge mipi_byte_clock);
    @(negedge mipi_byte_clock);
    if (response_valid !== 1'b1) begin
        fail_run($sformatf("%s: no response two cycles after %s", test_name, op.name()));
    end
    value = response;
endtask

task automatic check_read(input string what, input cmd_opcode_e op, input pixel_byte_t expected);
    pixel_byte_t value;
    read_byte(op, value);
    check_byte(what, expected, value);
endtask

task automatic read_count(output byte_count_t count);
    pixel_byte_t high;
    pixel_byte_t low;
    read_byte(CMD_READ_COUNT_HI, high);
    read_byte(CMD_READ_COUNT_LO, low);
    count = byte_count_t'({high, low});
endtask

task automatic set_window(input int x_start, input int x_end, input int y_start, input int y_end);
    send_command(CMD_SET_X_START, 1'b1, pixel_byte_t'(x_start));
    send_command(CMD_SET_X_END, 1'b1, pixel_byte_t'(x_end));
    send_command(CMD_SET_Y_START, 1'b1, pixel_byte_t'(y_start));
    send_command(CMD_SET_Y_END, 1'b1, pixel_byte_t'(y_end));
    win_x_start = x_start;
    win_x_end   = x_end;
    win_y_start = y_start;
    win_y_end   = y_end;
endtask

task automatic check_image(input pixel_byte_t status);
    byte_count_t count;
    int expected;
    expected = (stored.size() < `CAM_BUFFER_DEPTH) ? stored.size() : `CAM_BUFFER_DEPTH;
    read_count(count);
    check_count("byte count", byte_count_t'(expected), count);
    check_read("status", CMD_READ_STATUS, status);
endtask

// Needs the read pointer at zero
task automatic check_stored();
    int depth_count;
    depth_count = (stored.size() < `CAM_BUFFER_DEPTH) ? stored.size() : `CAM_BUFFER_DEPTH;
    for (int i = 0; i < depth_count; i++) begin
        check_read($sformatf("data byte %0d", i), CMD_READ_DATA, stored[i]);
    end
    check_read("data past the count", CMD_READ_DATA, 8'h00);
endtask

task automatic check_meter();
    check_read("peak", CMD_READ_PEAK, frame_peak);
    check_read("clipped", CMD_READ_CLIPPED,
               pixel_byte_t'((clipped_total > 255) ? 255 : clipped_total));
endtask

task automatic test_reset();
    byte_count_t count;
    test_name = "reset";
    check_read("status", CMD_READ_STATUS, 8'h00);
    read_count(count);
    check_count("byte count", '0, count);
    check_read("peak", CMD_READ_PEAK, 8'h00);
endtask

task automatic test_window();
    byte_count_t count;
    test_name = "window capture";
    set_window(3, 13, 2, 10);                           // Rows 2 to 9
    send_command(CMD_CAPTURE, 1'b0, 8'h00);
    send_frame(16, 12, 1'b0);
    stored = frame_bytes;
    read_count(count);
    check_count("window byte count", byte_count_t'(80), count);
    check_image(8'h01);
    check_meter();
    check_stored();
endtask

task automatic test_gating();
    test_name = "capture gating";
    send_frame(16, 12, 1'b0);                           // Not armed
    check_image(8'h01);
    send_command(CMD_CAPTURE, 1'b0, 8'h00);
    check_read("status while armed", CMD_READ_STATUS, 8'h03);
    check_stored();
    send_frame(16, 12, 1'b0);
    stored = frame_bytes;
    send_frame(16, 12, 1'b0);                           // Second frame is not taken
    check_image(8'h01);
    send_command(CMD_CAPTURE, 1'b0, 8'h00);             // Rewinds the read pointer
    check_stored();
endtask

task automatic test_metering();
    test_name = "metering";
    send_command(CMD_CAPTURE, 1'b0, 8'h00);
    send_frame(16, 12, 1'b1);
    check_meter();
    set_window(0, 255, 0, 255);
    send_command(CMD_CAPTURE, 1'b0, 8'h00);
    send_frame(32, 24, 1'b1);
    if (clipped_total <= 255) fail_run("metering: the frame has too few clipped pixels");
    check_meter();
endtask

task automatic test_buffer_full();
    test_name = "buffer full";
    send_command(CMD_CAPTURE, 1'b0, 8'h00);
    send_frame(80, 60, 1'b0);
    stored = frame_bytes;
    check_image(8'h01);
    check_stored();                                     // Last byte is model pixel 4095
endtask

initial begin
    frame_valid       <= 1'b0;
    line_valid        <= 1'b0;
    pixel_data        <= '0;
    op_code           <= 8'h00;
    op_code_valid     <= 1'b0;
    operand           <= 8'h00;
    operand_valid     <= 1'b0;
    operand_count     <= 0;
    mipi_byte_reset_n <= 1'b0;
    repeat (4) @(posedge mipi_byte_clock);
    mipi_byte_reset_n <= 1'b1;
    test_reset();
    test_window();
    test_gating();
    test_metering();
    test_buffer_full();
    $display("all tests passed");
    $finish;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge mipi_byte_clock);
    fail_run($sformatf("Timeout after %0d clock cycles in test %s", WATCHDOG_CYCLES, test_name));
end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/camera_pkg.sv
hdl/pixel_crop.sv
hdl/frame_metering.sv
hdl/image_buffer.sv
hdl/command_registers.sv
hdl/camera.sv
verification/camera_asserts.sv
verification/camera_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the camera capture testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module camera_tb -o camera_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/camera_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
